// File: list.f
source/core_pkg.sv
source/inst_decoder.sv
source/reg_file.sv
source/alu.sv
source/branch_unit.sv
source/core_ctrl.sv
source/rv_core.sv
tests/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - source/core_pkg.sv
  - source/inst_decoder.sv
  - source/reg_file.sv
  - source/alu.sv
  - source/branch_unit.sv
  - source/core_ctrl.sv
  - source/rv_core.sv
  - target: test
    files:
      - tests/tb_rv_core.sv

// File: tests/tb_rv_core.sv
`default_nettype none

module tb_rv_core;

    localparam logic [31:0] HALT_ADDR   = 32'h80;
    localparam logic [31:0] OP_PC       = 32'h10; // after the two operand loads
    localparam logic [31:0] RESULT_ADDR = 32'h100;
    localparam int          N_ROWS      = 33;
    localparam int          POST_HALT   = 10;

    typedef enum logic [4:0] {
        T_ADD, T_SUB, T_AND, T_OR, T_XOR, T_ADDI, T_ANDI, T_ORI, T_XORI,
        T_SLL, T_SRL, T_SRA, T_SRAI, T_SLT, T_SLTU,
        T_BEQ, T_BNE, T_BLT, T_BGE, T_BLTU, T_BGEU,
        T_JAL, T_JALR, T_LUI, T_AUIPC, T_LW
    } test_op_e;

    typedef struct packed {
        test_op_e    op;
        logic        rnd; // operands from the lfsr
        logic [31:0] a;
        logic [31:0] b;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_inst;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        dmem_wen;
    logic [31:0] gp;
    logic        halt;

    logic [31:0] imem [64];
    logic [31:0] dmem [256];
    logic [31:0] lfsr = 32'h1194;
    int          store_count = 0;
    int          wp = 0;
    int          n_rows = 0;
    int          row_errs = 0;
    row_t        rows [N_ROWS];
    string       names [N_ROWS];

    rv_core #(.HALT_PC(HALT_ADDR)) u_dut (
        .clk(clk), .rst_n(rst_n),
        .imem_addr_o(imem_addr), .imem_inst_i(imem_inst),
        .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata),
        .dmem_rdata_i(dmem_rdata), .dmem_wen_o(dmem_wen),
        .gp_o(gp), .halt_o(halt)
    );

    assign imem_inst  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // data memory refilled during every reset
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fill_word(i * 4);
            end
        end else if (dmem_wen) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
            store_count <= store_count + 1;
        end
    end

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0] ^ 16'h3c5a, ~addr[15:0]};
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            w = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic logic [31:0] rr_inst(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, 7'h33}; // x3 = x1 op x2
    endfunction

    function automatic logic [31:0] i_inst(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_inst(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_inst(input logic [12:0] off, input logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] j_inst(input logic [31:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    function automatic logic [2:0] branch_f3(input test_op_e op);
        case (op)
            T_BEQ:   return 3'b000;
            T_BNE:   return 3'b001;
            T_BLT:   return 3'b100;
            T_BGE:   return 3'b101;
            T_BLTU:  return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic logic [31:0] expected_result(input test_op_e op, input logic [31:0] a,
                                                    input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] sra;
        logic        ltu;
        logic        lt;
        sh  = b[4:0];
        sra = (a >> sh) | ({32{a[31]}} & ~(32'hffffffff >> sh));
        ltu = (a < b);
        lt  = (a[31] != b[31]) ? a[31] : ltu; // the negative one is less when signs differ
        case (op)
            T_ADD, T_ADDI: return a + b;
            T_SUB:         return a - b;
            T_AND, T_ANDI: return a & b;
            T_OR, T_ORI:   return a | b;
            T_XOR, T_XORI: return a ^ b;
            T_SLL:         return a << sh;
            T_SRL:         return a >> sh;
            T_SRA, T_SRAI: return sra;
            T_SLT:         return {31'b0, lt};
            T_SLTU:        return {31'b0, ltu};
            T_BEQ:         return (a == b) ? 32'd1 : 32'd2;
            T_BNE:         return (a != b) ? 32'd1 : 32'd2;
            T_BLT:         return lt ? 32'd1 : 32'd2;
            T_BGE:         return !lt ? 32'd1 : 32'd2;
            T_BLTU:        return ltu ? 32'd1 : 32'd2;
            T_BGEU:        return !ltu ? 32'd1 : 32'd2;
            T_JAL, T_JALR: return OP_PC + 32'd4;
            T_LUI:         return {a[31:12], 12'b0};
            T_AUIPC:       return OP_PC + {a[31:12], 12'b0};
            default:       return fill_word(a); // lw of a preset word
        endcase
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[wp] = w;
        wp++;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800; // addi sign-extends its low 12 bits
        emit({upper[31:12], rd, 7'h37});
        emit(i_inst(value[11:0], rd, 3'b000, rd, 7'h13));
    endtask

    // stray fetches jump straight to the halt address
    task automatic fill_imem();
        for (int i = 0; i < 64; i++) begin
            imem[i] = j_inst(HALT_ADDR - i * 4, 5'd0);
        end
    endtask

    task automatic build_program(input test_op_e op, input logic [31:0] a,
                                 input logic [31:0] b);
        fill_imem();
        wp = 0;
        load_const(5'd1, a);
        load_const(5'd2, b);
        case (op)
            T_ADD:  emit(rr_inst(7'h00, 3'b000));
            T_SUB:  emit(rr_inst(7'h20, 3'b000));
            T_AND:  emit(rr_inst(7'h00, 3'b111));
            T_OR:   emit(rr_inst(7'h00, 3'b110));
            T_XOR:  emit(rr_inst(7'h00, 3'b100));
            T_SLL:  emit(rr_inst(7'h00, 3'b001));
            T_SRL:  emit(rr_inst(7'h00, 3'b101));
            T_SRA:  emit(rr_inst(7'h20, 3'b101));
            T_SLT:  emit(rr_inst(7'h00, 3'b010));
            T_SLTU: emit(rr_inst(7'h00, 3'b011));
            T_ADDI: emit(i_inst(b[11:0], 5'd1, 3'b000, 5'd3, 7'h13));
            T_ANDI: emit(i_inst(b[11:0], 5'd1, 3'b111, 5'd3, 7'h13));
            T_ORI:  emit(i_inst(b[11:0], 5'd1, 3'b110, 5'd3, 7'h13));
            T_XORI: emit(i_inst(b[11:0], 5'd1, 3'b100, 5'd3, 7'h13));
            T_SRAI: emit(i_inst({7'h20, b[4:0]}, 5'd1, 3'b101, 5'd3, 7'h13));
            T_BEQ, T_BNE, T_BLT, T_BGE, T_BLTU, T_BGEU: begin
                emit(i_inst(12'd1, 5'd0, 3'b000, 5'd3, 7'h13));
                emit(b_inst(13'd8, branch_f3(op))); // taken skips the next one
                emit(i_inst(12'd2, 5'd0, 3'b000, 5'd3, 7'h13));
            end
            T_JAL: begin
                emit(j_inst(32'd8, 5'd3));
                emit(i_inst(12'd99, 5'd0, 3'b000, 5'd3, 7'h13));
            end
            T_JALR: begin
                emit(i_inst(12'd0, 5'd1, 3'b000, 5'd3, 7'h67));
                emit(i_inst(12'd99, 5'd0, 3'b000, 5'd3, 7'h13));
            end
            T_LUI:   emit({a[31:12], 5'd3, 7'h37});
            T_AUIPC: emit({a[31:12], 5'd3, 7'h17});
            default: emit(i_inst(12'd0, 5'd1, 3'b010, 5'd3, 7'h03)); // lw x3, 0(x1)
        endcase
        emit(s_inst(RESULT_ADDR[11:0], 5'd3, 5'd0));
        emit(j_inst(HALT_ADDR - wp * 4, 5'd0));
    endtask

    task automatic add_row(input string name, input test_op_e op, input logic [31:0] a,
                           input logic [31:0] b, input logic rnd);
        names[n_rows] = name;
        rows[n_rows]  = '{op: op, rnd: rnd, a: a, b: b};
        n_rows++;
    endtask

    task automatic load_table();
        add_row("add_fixed",  T_ADD,   32'h12345678, 32'h0fedcba9, 1'b0);
        add_row("add_rand",   T_ADD,   32'h0,        32'h0,        1'b1);
        add_row("sub_rand",   T_SUB,   32'h0,        32'h0,        1'b1);
        add_row("and_rand",   T_AND,   32'h0,        32'h0,        1'b1);
        add_row("or_rand",    T_OR,    32'h0,        32'h0,        1'b1);
        add_row("xor_rand",   T_XOR,   32'h0,        32'h0,        1'b1);
        add_row("addi_neg",   T_ADDI,  32'h00001000, 32'hfffff800, 1'b0);
        add_row("addi_rand",  T_ADDI,  32'h0,        32'h0,        1'b1);
        add_row("andi_rand",  T_ANDI,  32'h0,        32'h0,        1'b1);
        add_row("ori_rand",   T_ORI,   32'h0,        32'h0,        1'b1);
        add_row("xori_rand",  T_XORI,  32'h0,        32'h0,        1'b1);
        add_row("sll_rand",   T_SLL,   32'h0,        32'h0,        1'b1);
        add_row("srl_rand",   T_SRL,   32'h0,        32'h0,        1'b1);
        add_row("sra_neg",    T_SRA,   32'h80000010, 32'd4,        1'b0);
        add_row("srai_neg",   T_SRAI,  32'hfffff000, 32'd8,        1'b0);
        add_row("sra_rand",   T_SRA,   32'h0,        32'h0,        1'b1);
        add_row("slt_mixed",  T_SLT,   32'hffffffff, 32'd1,        1'b0);
        add_row("sltu_mixed", T_SLTU,  32'hffffffff, 32'd1,        1'b0);
        add_row("slt_rand",   T_SLT,   32'h0,        32'h0,        1'b1);
        add_row("sltu_rand",  T_SLTU,  32'h0,        32'h0,        1'b1);
        add_row("beq_taken",  T_BEQ,   32'd5,        32'd5,        1'b0);
        add_row("beq_not",    T_BEQ,   32'd5,        32'd6,        1'b0);
        add_row("bne_taken",  T_BNE,   32'd5,        32'd6,        1'b0);
        add_row("blt_taken",  T_BLT,   32'hfffffffd, 32'd2,        1'b0);
        add_row("bge_not",    T_BGE,   32'hfffffffd, 32'd2,        1'b0);
        add_row("bge_equal",  T_BGE,   32'd7,        32'd7,        1'b0);
        add_row("bltu_not",   T_BLTU,  32'hfffffffd, 32'd2,        1'b0);
        add_row("bgeu_taken", T_BGEU,  32'hfffffffd, 32'd2,        1'b0);
        add_row("jal_link",   T_JAL,   32'h0,        32'h0,        1'b0);
        add_row("jalr_odd",   T_JALR,  32'h19,       32'h0,        1'b0); // lands on 0x18
        add_row("lui_rand",   T_LUI,   32'h0,        32'h0,        1'b1);
        add_row("auipc_rand", T_AUIPC, 32'h0,        32'h0,        1'b1);
        add_row("lw_preset",  T_LW,    32'h180,      32'h0,        1'b0);
    endtask

    task automatic check_word(input string name, input string what,
                              input logic [31:0] exp, input logic [31:0] got);
        logic ok;
        ok = (exp === got);
        assert (ok) else $display("mismatch %s %s: expected %h, actual %h", name, what, exp, got);
        if (!ok) row_errs++;
    endtask

    task automatic check_true(input string name, input logic cond, input string what);
        assert (cond === 1'b1) else $display("%s: %s", name, what);
        if (cond !== 1'b1) row_errs++;
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp;
        int          stores_snap;
        int          pass_cnt;
        int          fail_cnt;
        rst_n    = 1'b0;
        pass_cnt = 0;
        fail_cnt = 0;
        fill_imem();
        load_table();
        for (int r = 0; r < n_rows; r++) begin
            a = rows[r].a;
            b = rows[r].b;
            if (rows[r].rnd) begin
                a = rand_word();
                b = rand_word();
            end
            if (rows[r].op inside {T_ADDI, T_ANDI, T_ORI, T_XORI, T_SRAI}) begin
                b = {{20{b[11]}}, b[11:0]};
            end
            exp = expected_result(rows[r].op, a, b);
            row_errs = 0;
            @(negedge clk);
            rst_n = 1'b0;
            build_program(rows[r].op, a, b);
            repeat (5) @(negedge clk);
            rst_n = 1'b1;
            while (!halt) @(negedge clk);
            check_word(names[r], "gp", exp, gp);
            check_word(names[r], "mem[0x100]", exp, dmem[RESULT_ADDR[9:2]]);
            stores_snap = store_count;
            repeat (POST_HALT) @(negedge clk);
            check_word(names[r], "gp after halt", exp, gp);
            check_word(names[r], "mem[0x100] after halt", exp, dmem[RESULT_ADDR[9:2]]);
            check_true(names[r], store_count == stores_snap, "a store happened after halt");
            check_true(names[r], halt, "halt dropped while the core should stay stopped");
            if (row_errs == 0) begin
                pass_cnt++;
            end else begin
                fail_cnt++;
            end
            $display("%s: %s", names[r], (row_errs == 0) ? "ok" : "FAILED");
        end
        $display("%0d rows ok, %0d rows failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // about 40 cycles per row covers reset, program and the post-halt window
    initial begin
        #(N_ROWS * 40 * 8);
        $display("watchdog: run exceeded %0d cycles, the core never halted", N_ROWS * 40);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/rv_core.sv
`default_nettype none

module rv_core #(
    parameter core_pkg::xlen_t RESET_PC = 32'h0,
    parameter core_pkg::xlen_t HALT_PC  = 32'h44
) (
    input  wire                  clk,
    input  wire                  rst_n,
    output core_pkg::xlen_t      imem_addr_o,
    input  wire core_pkg::xlen_t imem_inst_i,
    output core_pkg::xlen_t      dmem_addr_o,
    output core_pkg::xlen_t      dmem_wdata_o,
    input  wire core_pkg::xlen_t dmem_rdata_i,
    output logic                 dmem_wen_o,
    output core_pkg::xlen_t      gp_o,
    output logic                 halt_o
);
    import core_pkg::*;

    inst_u inst;
    ctrl_t ctrl;
    xlen_t imm;
    xlen_t pc;
    xlen_t rs1_data;
    xlen_t rs2_data;
    xlen_t op1;
    xlen_t op2;
    xlen_t alu_y;
    xlen_t br_target;
    xlen_t rf_wdata;
    logic  br_taken;
    logic  rf_wen;

    assign inst = imem_inst_i;

    inst_decoder u_decoder (.inst_i(inst), .ctrl_o(ctrl), .imm_o(imm));

    reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n),
        .rs1_i(ctrl.rs1), .rs2_i(ctrl.rs2),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .wen_i(rf_wen), .rd_i(ctrl.rd), .wdata_i(rf_wdata),
        .gp_o(gp_o)
    );

    // operand muxes
    always_comb begin
        case (ctrl.op1_sel)
            OP1_PC:   op1 = pc;
            OP1_ZERO: op1 = '0; // lui
            default:  op1 = rs1_data;
        endcase
    end
    assign op2 = (ctrl.op2_sel == OP2_IMM) ? imm : rs2_data;

    alu u_alu (.op_i(ctrl.alu_op), .a_i(op1), .b_i(op2), .y_o(alu_y));

    branch_unit u_branch (
        .op_i(ctrl.br_op), .a_i(op1), .b_i(op2),
        .pc_i(pc), .imm_i(imm),
        .taken_o(br_taken), .target_o(br_target)
    );

    core_ctrl #(.RESET_PC(RESET_PC), .HALT_PC(HALT_PC)) u_ctrl (
        .clk(clk), .rst_n(rst_n), .ctrl_i(ctrl),
        .alu_y_i(alu_y), .br_taken_i(br_taken), .br_target_i(br_target),
        .dmem_rdata_i(dmem_rdata_i),
        .pc_o(pc), .rf_wen_o(rf_wen), .rf_wdata_o(rf_wdata),
        .dmem_wen_o(dmem_wen_o), .halt_o(halt_o)
    );

    assign imem_addr_o  = pc;
    assign dmem_addr_o  = alu_y;
    assign dmem_wdata_o = rs2_data;

endmodule

`default_nettype wire

// File: source/core_ctrl.sv
`default_nettype none

module core_ctrl #(
    parameter core_pkg::xlen_t RESET_PC = 32'h0,
    parameter core_pkg::xlen_t HALT_PC  = 32'h44
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire core_pkg::ctrl_t ctrl_i,
    input  wire core_pkg::xlen_t alu_y_i,
    input  wire                  br_taken_i,
    input  wire core_pkg::xlen_t br_target_i,
    input  wire core_pkg::xlen_t dmem_rdata_i,
    output core_pkg::xlen_t      pc_o,
    output logic                 rf_wen_o,
    output core_pkg::xlen_t      rf_wdata_o,
    output logic                 dmem_wen_o,
    output logic                 halt_o
);
    import core_pkg::*;

    typedef enum logic [1:0] {S_WAIT, S_LOAD_WAIT, S_EXEC} state_e;

    state_e state;
    xlen_t  pc_q;
    xlen_t  pc_plus4;
    xlen_t  next_pc;
    logic   exec;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_WAIT;
        end else begin
            case (state)
                S_WAIT:      state <= (ctrl_i.wb_sel == WB_MEM) ? S_LOAD_WAIT : S_EXEC;
                S_LOAD_WAIT: state <= S_EXEC; // data port gets a cycle
                default:     state <= S_WAIT;
            endcase
        end
    end

    assign halt_o   = (pc_q == HALT_PC);
    assign exec     = (state == S_EXEC) && !halt_o;
    assign pc_plus4 = pc_q + 32'd4;

    // branch first, then jump
    assign next_pc = br_taken_i  ? br_target_i :
                     ctrl_i.jump ? alu_y_i     :
                                   pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (exec) begin
            pc_q <= next_pc;
        end
    end

    always_comb begin
        case (ctrl_i.wb_sel)
            WB_MEM:  rf_wdata_o = dmem_rdata_i;
            WB_PC4:  rf_wdata_o = pc_plus4;
            default: rf_wdata_o = alu_y_i;
        endcase
    end

    assign pc_o       = pc_q;
    assign rf_wen_o   = exec && ctrl_i.rf_wen;
    assign dmem_wen_o = exec && ctrl_i.mem_wen;

    assert property (@(posedge clk) disable iff (!rst_n) !(dmem_wen_o && rf_wen_o))
        else $error("core_ctrl: store and register write in the same cycle");

    // once halted only reset brings the pc back
    assert property (@(posedge clk) $fell(halt_o) |-> $past(!rst_n))
        else $error("core_ctrl: halt dropped without reset");

endmodule

`default_nettype wire

// File: source/branch_unit.sv
`default_nettype none

module branch_unit (
    input  wire core_pkg::br_op_e op_i,
    input  wire core_pkg::xlen_t  a_i,
    input  wire core_pkg::xlen_t  b_i,
    input  wire core_pkg::xlen_t  pc_i,
    input  wire core_pkg::xlen_t  imm_i,
    output logic                  taken_o,
    output core_pkg::xlen_t       target_o
);
    import core_pkg::*;

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = (a_i == b_i);
    assign lt  = ($signed(a_i) < $signed(b_i));
    assign ltu = (a_i < b_i);

    always_comb begin
        case (op_i)
            BR_BEQ:  taken_o = eq;
            BR_BNE:  taken_o = !eq;
            BR_BLT:  taken_o = lt;
            BR_BGE:  taken_o = !lt;  // not less than
            BR_BLTU: taken_o = ltu;
            BR_BGEU: taken_o = !ltu;
            default: taken_o = 1'b0;
        endcase
    end

    assign target_o = pc_i + imm_i;

endmodule

`default_nettype wire

// File: source/alu.sv
`default_nettype none

module alu (
    input  wire core_pkg::alu_op_e op_i,
    input  wire core_pkg::xlen_t   a_i,
    input  wire core_pkg::xlen_t   b_i,
    output core_pkg::xlen_t        y_o
);
    import core_pkg::*;

    logic [4:0] shamt;
    xlen_t      sum;

    assign shamt = b_i[4:0];
    assign sum   = a_i + b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:  y_o = sum;
            ALU_SUB:  y_o = a_i - b_i;
            ALU_AND:  y_o = a_i & b_i;
            ALU_OR:   y_o = a_i | b_i;
            ALU_XOR:  y_o = a_i ^ b_i;
            ALU_SLL:  y_o = a_i << shamt;
            ALU_SRL:  y_o = a_i >> shamt;
            ALU_SRA:  y_o = $signed(a_i) >>> shamt;
            ALU_SLT:  y_o = {31'b0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: y_o = {31'b0, a_i < b_i};
            ALU_JALR: y_o = {sum[31:1], 1'b0}; // jump targets are even
            default:  y_o = '0;
        endcase
    end

    // no clock here, so checked once the op has settled
    always_comb begin
        assert final (op_i inside {[ALU_ADD:ALU_JALR]})
            else $error("alu: op %0d not a legal alu_op_e value", op_i);
    end

endmodule

`default_nettype wire

// File: source/reg_file.sv
`default_nettype none

module reg_file (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire core_pkg::reg_addr_t rs1_i,
    input  wire core_pkg::reg_addr_t rs2_i,
    output core_pkg::xlen_t          rs1_data_o,
    output core_pkg::xlen_t          rs2_data_o,
    input  wire                      wen_i,
    input  wire core_pkg::reg_addr_t rd_i,
    input  wire core_pkg::xlen_t     wdata_i,
    output core_pkg::xlen_t          gp_o
);
    import core_pkg::*;

    xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && rd_i != '0) begin // x0 stays zero
            regs[rd_i] <= wdata_i;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];
    assign gp_o       = regs[3];

    // control side must have settled into wait by the second reset cycle
    assert property (@(posedge clk) !rst_n ##1 !rst_n |-> !wen_i)
        else $error("reg_file: write enabled during reset");

endmodule

`default_nettype wire

// File: source/inst_decoder.sv
`default_nettype none

module inst_decoder (
    input  wire core_pkg::inst_u inst_i,
    output core_pkg::ctrl_t      ctrl_o,
    output core_pkg::xlen_t      imm_o
);
    import core_pkg::*;

    always_comb begin
        // do-nothing defaults, also what unknown words end up with
        ctrl_o.alu_op  = ALU_ADD;
        ctrl_o.br_op   = BR_NONE;
        ctrl_o.op1_sel = OP1_RS1;
        ctrl_o.op2_sel = OP2_RS2;
        ctrl_o.wb_sel  = WB_ALU;
        ctrl_o.rf_wen  = 1'b0;
        ctrl_o.mem_wen = 1'b0;
        ctrl_o.jump    = 1'b0;
        ctrl_o.rd      = inst_i.r_fmt.rd;
        ctrl_o.rs1     = inst_i.r_fmt.rs1;
        ctrl_o.rs2     = inst_i.r_fmt.rs2;
        case (inst_i.r_fmt.opcode)
            OP_REG: begin
                ctrl_o.rf_wen = 1'b1;
                case ({inst_i.r_fmt.funct7, inst_i.r_fmt.funct3})
                    {7'h00, 3'b000}: ctrl_o.alu_op = ALU_ADD;
                    {7'h20, 3'b000}: ctrl_o.alu_op = ALU_SUB;
                    {7'h00, 3'b001}: ctrl_o.alu_op = ALU_SLL;
                    {7'h00, 3'b010}: ctrl_o.alu_op = ALU_SLT;
                    {7'h00, 3'b011}: ctrl_o.alu_op = ALU_SLTU;
                    {7'h00, 3'b100}: ctrl_o.alu_op = ALU_XOR;
                    {7'h00, 3'b101}: ctrl_o.alu_op = ALU_SRL;
                    {7'h20, 3'b101}: ctrl_o.alu_op = ALU_SRA;
                    {7'h00, 3'b110}: ctrl_o.alu_op = ALU_OR;
                    {7'h00, 3'b111}: ctrl_o.alu_op = ALU_AND;
                    default:         ctrl_o.rf_wen = 1'b0;
                endcase
            end
            OP_IMM: begin
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.rf_wen  = 1'b1;
                case (inst_i.r_fmt.funct3)
                    3'b000: ctrl_o.alu_op = ALU_ADD;
                    3'b010: ctrl_o.alu_op = ALU_SLT;
                    3'b011: ctrl_o.alu_op = ALU_SLTU;
                    3'b100: ctrl_o.alu_op = ALU_XOR;
                    3'b110: ctrl_o.alu_op = ALU_OR;
                    3'b111: ctrl_o.alu_op = ALU_AND;
                    3'b001: begin
                        ctrl_o.alu_op = ALU_SLL;
                        ctrl_o.rf_wen = (inst_i.r_fmt.funct7 == 7'h00);
                    end
                    default: begin // srli / srai
                        ctrl_o.alu_op = (inst_i.r_fmt.funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
                        ctrl_o.rf_wen = (inst_i.r_fmt.funct7 == 7'h00)
                                     || (inst_i.r_fmt.funct7 == 7'h20);
                    end
                endcase
            end
            OP_LOAD: begin
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.wb_sel  = WB_MEM;
                ctrl_o.rf_wen  = (inst_i.i_fmt.funct3 == 3'b010); // lw only
            end
            OP_STORE: begin
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.mem_wen = (inst_i.s_fmt.funct3 == 3'b010); // sw only
            end
            OP_BRANCH: begin
                case (inst_i.b_fmt.funct3)
                    3'b000:  ctrl_o.br_op = BR_BEQ;
                    3'b001:  ctrl_o.br_op = BR_BNE;
                    3'b100:  ctrl_o.br_op = BR_BLT;
                    3'b101:  ctrl_o.br_op = BR_BGE;
                    3'b110:  ctrl_o.br_op = BR_BLTU;
                    3'b111:  ctrl_o.br_op = BR_BGEU;
                    default: ctrl_o.br_op = BR_NONE;
                endcase
            end
            OP_JAL: begin
                ctrl_o.op1_sel = OP1_PC;
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.wb_sel  = WB_PC4;
                ctrl_o.rf_wen  = 1'b1;
                ctrl_o.jump    = 1'b1;
            end
            OP_JALR: begin
                ctrl_o.alu_op  = ALU_JALR;
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.wb_sel  = WB_PC4;
                ctrl_o.rf_wen  = (inst_i.i_fmt.funct3 == 3'b000);
                ctrl_o.jump    = (inst_i.i_fmt.funct3 == 3'b000);
            end
            OP_LUI: begin
                ctrl_o.op1_sel = OP1_ZERO;
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.rf_wen  = 1'b1;
            end
            OP_AUIPC: begin
                ctrl_o.op1_sel = OP1_PC;
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.rf_wen  = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (inst_i.r_fmt.opcode)
            OP_IMM, OP_LOAD, OP_JALR:
                imm_o = {{20{inst_i.i_fmt.imm_11_0[11]}}, inst_i.i_fmt.imm_11_0};
            OP_STORE:
                imm_o = {{20{inst_i.s_fmt.imm_11_5[6]}}, inst_i.s_fmt.imm_11_5,
                         inst_i.s_fmt.imm_4_0};
            OP_BRANCH:
                imm_o = {{20{inst_i.b_fmt.imm_12}}, inst_i.b_fmt.imm_11,
                         inst_i.b_fmt.imm_10_5, inst_i.b_fmt.imm_4_1, 1'b0};
            OP_JAL:
                imm_o = {{12{inst_i.j_fmt.imm_20}}, inst_i.j_fmt.imm_19_12,
                         inst_i.j_fmt.imm_11, inst_i.j_fmt.imm_10_1, 1'b0};
            OP_LUI, OP_AUIPC:
                imm_o = {inst_i.u_fmt.imm_31_12, 12'b0};
            default:
                imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;

    // rv32i major opcodes used by this core
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        opcode_e    opcode;
    } j_fmt_t;

    // one instruction word, six ways to read it
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_JALR // sum with bit 0 cleared
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_op_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;
    typedef enum logic {OP2_RS2, OP2_IMM} op2_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        br_op_e    br_op;
        op1_sel_e  op1_sel;
        op2_sel_e  op2_sel;
        wb_sel_e   wb_sel;
        logic      rf_wen;
        logic      mem_wen;
        logic      jump;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } ctrl_t;

endpackage

`default_nettype wire
